// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_eeprom_master -f vlog.f -o tb_eeprom_master

out=$(./obj_dir/tb_eeprom_master)
echo "$out"

echo "$out" | grep -q "^Regression passed$"

// ==== source/bus_shifter.sv ====
`timescale 1ns/100ps

module bus_shifter import eeprom_pkg::*; (
    input  logic         CLK,
    input  logic         RESET,
    output logic         sda_low,   // 1 pulls SDA down
    input  logic         sda_in,
    bus_slot_if.shifter  slot_bus
);

    sym_t       kind;
    ee_byte_t   shreg;
    logic [3:0] slot_cnt;   // 0..8, slot 8 is the ack bit
    logic       last_slot;
    logic       bit_slot;   // one of the eight data slots

    assign bit_slot  = (slot_cnt != 4'd8);
    assign last_slot = (kind == SYM_START || kind == SYM_STOP) ? (slot_cnt == 4'd0)
                                                                : (slot_cnt == 4'd8);

    assign slot_bus.rx_byte = shreg;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            slot_bus.run      <= 1'b0;
            slot_bus.sym_done <= 1'b0;
            slot_bus.ack_bad  <= 1'b0;
            sda_low           <= 1'b0;
            kind              <= SYM_STOP;
            slot_cnt          <= 4'd0;
        end else begin
            slot_bus.sym_done <= 1'b0;
            if (!slot_bus.run) begin
                if (slot_bus.sym_go) begin
                    kind         <= slot_bus.sym;
                    slot_cnt     <= 4'd0;
                    slot_bus.run <= 1'b1;
                end
            end else begin
                if (slot_bus.tick_low) begin
                    unique case (kind)
                        SYM_START: sda_low <= 1'b0;   // release before the falling edge
                        SYM_STOP:  sda_low <= 1'b1;
                        SYM_TX:    sda_low <= bit_slot ? ~shreg[7] : 1'b0;
                        SYM_RX:    sda_low <= bit_slot ? 1'b0 : ~slot_bus.rx_nack;
                    endcase
                end
                if (slot_bus.tick_high) begin
                    if (kind == SYM_START)
                        sda_low <= 1'b1;              // falling SDA with SCL high
                    else if (kind == SYM_STOP)
                        sda_low <= 1'b0;
                    else if (kind == SYM_TX && !bit_slot)
                        slot_bus.ack_bad <= sda_in;
                end
                if (slot_bus.slot_end) begin
                    if (last_slot) begin
                        slot_bus.run      <= 1'b0;
                        slot_bus.sym_done <= 1'b1;
                    end else begin
                        slot_cnt <= slot_cnt + 4'd1;
                    end
                end
            end
        end
    end

    // shift register, MSB first both ways
    always_ff @(posedge CLK) begin
        if (slot_bus.sym_go && !slot_bus.run)
            shreg <= slot_bus.tx_byte;
        else if (slot_bus.tick_low && kind == SYM_TX && bit_slot)
            shreg <= {shreg[6:0], 1'b0};
        else if (slot_bus.tick_high && kind == SYM_RX && bit_slot)
            shreg <= {shreg[6:0], sda_in};
    end

endmodule

// ==== source/bus_slot_if.sv ====
`timescale 1ns/100ps

interface bus_slot_if import eeprom_pkg::*; ();

    logic     sym_go;     // one-cycle request
    sym_t     sym;
    ee_byte_t tx_byte;
    logic     rx_nack;    // 1 leaves SDA released in the ack bit

    logic     tick_low;   // mid SCL low
    logic     tick_high;  // mid SCL high
    logic     slot_end;

    logic     run;
    logic     sym_done;
    ee_byte_t rx_byte;
    logic     ack_bad;    // no ack seen after the last byte sent

    modport ctrl (output sym_go, sym, tx_byte, rx_nack,
                  input  run, sym_done, rx_byte, ack_bad);

    modport timer (input  run,
                   output tick_low, tick_high, slot_end);

    modport shifter (input  sym_go, sym, tx_byte, rx_nack,
                     input  tick_low, tick_high, slot_end,
                     output run, sym_done, rx_byte, ack_bad);

endinterface

// ==== source/eeprom_ctrl.sv ====
`timescale 1ns/100ps

module eeprom_ctrl import eeprom_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      wr,
    input  logic      rd,
    input  ee_addr_t  addr,
    input  ee_byte_t  wdata,
    output ee_byte_t  rdata,
    output logic      busy,
    output logic      done,
    output logic      nack,
    bus_slot_if.ctrl  slot_bus
);

    ctrl_state_t state;
    ctrl_state_t nxt;

    ee_addr_t addr_q;
    ee_byte_t wdata_q;
    logic     op_rd;
    ee_byte_t ctrl_w;
    ee_byte_t ctrl_r;
    logic     accept;
    logic     go_next;    // current symbol finished
    logic     tx_state;   // states that send a byte and expect an ack

    assign ctrl_w = {DEVICE_CODE, addr_q[10:8], 1'b0};
    assign ctrl_r = {DEVICE_CODE, addr_q[10:8], 1'b1};

    assign accept   = (state == ST_IDLE) && (wr || rd) && !slot_bus.run;
    assign go_next  = (state != ST_IDLE) && slot_bus.sym_done;
    assign tx_state = state inside {ST_CTRL_W, ST_WORD, ST_DATA_W, ST_CTRL_R};

    always_comb begin
        nxt = state;
        unique case (state)
            ST_IDLE: begin
                if (accept)
                    nxt = ST_START;
            end
            ST_START:   nxt = ST_CTRL_W;
            ST_CTRL_W:  nxt = slot_bus.ack_bad ? ST_STOP : ST_WORD;
            ST_WORD: begin
                if (slot_bus.ack_bad)
                    nxt = ST_STOP;
                else if (op_rd)
                    nxt = ST_RESTART;   // dummy write done, turn the bus around
                else
                    nxt = ST_DATA_W;
            end
            ST_DATA_W:  nxt = ST_STOP;
            ST_RESTART: nxt = ST_CTRL_R;
            ST_CTRL_R:  nxt = slot_bus.ack_bad ? ST_STOP : ST_DATA_R;
            ST_DATA_R:  nxt = ST_STOP;
            ST_STOP:    nxt = ST_IDLE;
            default:    nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state            <= ST_IDLE;
            busy             <= 1'b0;
            done             <= 1'b0;
            nack             <= 1'b0;
            slot_bus.sym_go  <= 1'b0;
            slot_bus.sym     <= SYM_STOP;
            slot_bus.rx_nack <= 1'b0;
        end else begin
            slot_bus.sym_go <= 1'b0;
            done            <= 1'b0;

            if (accept || go_next) begin
                state <= nxt;
                if (nxt == ST_IDLE) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    busy            <= 1'b1;
                    slot_bus.sym_go <= 1'b1;   // lands the cycle after sym_done
                    unique case (nxt)
                        ST_START,
                        ST_RESTART: slot_bus.sym <= SYM_START;
                        ST_STOP:    slot_bus.sym <= SYM_STOP;
                        ST_DATA_R:  slot_bus.sym <= SYM_RX;
                        default:    slot_bus.sym <= SYM_TX;
                    endcase
                    // single read byte, always answered with a nack
                    slot_bus.rx_nack <= (nxt == ST_DATA_R);
                end
            end

            if (accept)
                nack <= 1'b0;
            else if (go_next && tx_state && slot_bus.ack_bad)
                nack <= 1'b1;
        end
    end

    // request payload and the byte for the next symbol
    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            op_rd   <= ~wr;   // wr wins
        end
        if (accept || go_next) begin
            case (nxt)
                ST_CTRL_W: slot_bus.tx_byte <= ctrl_w;
                ST_WORD:   slot_bus.tx_byte <= addr_q[7:0];
                ST_DATA_W: slot_bus.tx_byte <= wdata_q;
                ST_CTRL_R: slot_bus.tx_byte <= ctrl_r;
                default:   slot_bus.tx_byte <= slot_bus.tx_byte;
            endcase
        end
        if (go_next && state == ST_DATA_R)
            rdata <= slot_bus.rx_byte;
    end

endmodule

// ==== source/eeprom_master.sv ====
`timescale 1ns/100ps

module eeprom_master import eeprom_pkg::*; #(
    parameter int QUARTER = 2   // clocks per quarter of a bit slot
) (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_byte_t wdata,
    output ee_byte_t rdata,
    output logic     busy,
    output logic     done,
    output logic     nack,
    output logic     scl,
    output logic     sda_low,
    input  logic     sda_in
);

    bus_slot_if slot_bus ();

    eeprom_ctrl ctrl0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .busy     (busy),
        .done     (done),
        .nack     (nack),
        .slot_bus (slot_bus)
    );

    scl_timer #(
        .QUARTER (QUARTER)
    ) timer0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .slot_bus (slot_bus)
    );

    // open-drain pair, the line itself is resolved outside
    bus_shifter shift0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .sda_low  (sda_low),
        .sda_in   (sda_in),
        .slot_bus (slot_bus)
    );

endmodule

// ==== source/eeprom_pkg.sv ====
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;  // block in [10:8], word in [7:0]
    typedef logic [7:0]  ee_byte_t;

    // what the shifter can put on the wire as one unit
    typedef enum logic [1:0] {
        SYM_START,
        SYM_STOP,
        SYM_TX,
        SYM_RX
    } sym_t;

    typedef enum logic [8:0] {
        ST_IDLE    = 9'b0_0000_0001,
        ST_START   = 9'b0_0000_0010,
        ST_CTRL_W  = 9'b0_0000_0100,
        ST_WORD    = 9'b0_0000_1000,
        ST_DATA_W  = 9'b0_0001_0000,
        ST_RESTART = 9'b0_0010_0000,
        ST_CTRL_R  = 9'b0_0100_0000,
        ST_DATA_R  = 9'b0_1000_0000,
        ST_STOP    = 9'b1_0000_0000
    } ctrl_state_t;

    // device type field, top nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

// ==== source/scl_timer.sv ====
`timescale 1ns/100ps

module scl_timer #(
    parameter int QUARTER = 2
) (
    input  logic       CLK,
    input  logic       RESET,
    output logic       scl,
    bus_slot_if.timer  slot_bus
);

    // width of the quarter counter, at least one bit
    localparam int QW = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    logic [QW-1:0] q_cnt;
    logic [1:0]    phase;   // quarter within the bit slot
    logic          q_last;

    assign q_last = (q_cnt == QW'(QUARTER - 1));

    // counter parks at zero between symbols
    always_ff @(posedge CLK) begin
        if (RESET || !slot_bus.run) begin
            q_cnt <= '0;
            phase <= 2'd0;
        end else if (q_last) begin
            q_cnt <= '0;
            phase <= phase + 2'd1;
        end else begin
            q_cnt <= q_cnt + 1'b1;
        end
    end

    /*
     * Quarters 0 and 1 hold SCL low, 2 and 3 hold it high.
     * The line sits high whenever no symbol is running.
     */
    assign scl = ~slot_bus.run | phase[1];

    assign slot_bus.tick_low  = slot_bus.run & q_last & (phase == 2'd0);
    assign slot_bus.tick_high = slot_bus.run & q_last & (phase == 2'd2);
    assign slot_bus.slot_end  = slot_bus.run & q_last & (phase == 2'd3);

endmodule

// ==== test/eeprom_model.sv ====
`timescale 1ns/100ps

module eeprom_model import eeprom_pkg::*; (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,       // resolved line
    input  logic present,   // low makes the device ignore its address
    input  logic done,      // end of a master transaction
    output logic pull       // 1 drives SDA low
);

    localparam logic [2:0] M_IDLE = 3'd0;
    localparam logic [2:0] M_CTRL = 3'd1;
    localparam logic [2:0] M_WORD = 3'd2;
    localparam logic [2:0] M_DATA = 3'd3;
    localparam logic [2:0] M_READ = 3'd4;
    localparam logic [2:0] M_WAIT = 3'd5;

    ee_byte_t   mem [2048];
    logic       scl_q;
    logic       sda_q;
    logic [3:0] bit_cnt;    // SCL rises counted in this byte with 8 for the ack
    logic [2:0] mode;
    ee_byte_t   shreg;
    ee_byte_t   out_byte;
    logic [2:0] block;
    ee_byte_t   word;
    logic       in_txn;
    logic       hi_change;  // SDA moved while SCL stayed high
    logic [3:0] edge_cnt;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_seen;
    logic       stop_seen;
    int         proto_errs = 0;

    assign scl_rise   = scl && !scl_q;
    assign scl_fall   = !scl && scl_q;
    assign start_seen = scl && scl_q && sda_q && !sda;
    assign stop_seen  = scl && scl_q && !sda_q && sda;

    // sampled on falling CLK edges while the master moves its lines on rising ones
    always @(negedge CLK) begin
        if (RESET) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            bit_cnt   <= 4'd0;
            mode      <= M_IDLE;
            in_txn    <= 1'b0;
            pull      <= 1'b0;
            hi_change <= 1'b0;
            edge_cnt  <= 4'd0;
            for (int i = 0; i < 2048; i++)
                mem[11'(i)] <= 8'hFF;   // erased
        end else begin
            scl_q     <= scl;
            sda_q     <= sda;
            hi_change <= scl && scl_q && (sda != sda_q);
            edge_cnt  <= bit_cnt;
            if (start_seen) begin
                mode    <= M_CTRL;
                bit_cnt <= 4'd0;
                in_txn  <= 1'b1;
                pull    <= 1'b0;
            end else if (stop_seen) begin
                mode    <= M_IDLE;
                bit_cnt <= 4'd0;
                in_txn  <= 1'b0;
                pull    <= 1'b0;
            end else if (scl_rise) begin
                if (bit_cnt == 4'd8) begin
                    bit_cnt <= 4'd0;   // ack clock
                end else begin
                    shreg   <= {shreg[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (scl_fall) begin
                pull <= 1'b0;
                if (bit_cnt == 4'd8) begin
                    case (mode)
                        M_CTRL: begin
                            if (shreg[7:4] == DEVICE_CODE && present) begin
                                pull  <= 1'b1;
                                block <= shreg[3:1];
                                if (shreg[0]) begin
                                    mode     <= M_READ;
                                    out_byte <= mem[{shreg[3:1], word}];
                                end else begin
                                    mode <= M_WORD;
                                end
                            end else begin
                                mode <= M_WAIT;
                            end
                        end
                        M_WORD: begin
                            pull <= 1'b1;
                            word <= shreg;
                            mode <= M_DATA;
                        end
                        M_DATA: begin
                            pull             <= 1'b1;
                            mem[{block, word}] <= shreg;   // instant write cycle
                            mode             <= M_WAIT;
                        end
                        M_READ: mode <= M_WAIT;   // one byte only
                        default: ;
                    endcase
                end else if (mode == M_READ) begin
                    pull     <= ~out_byte[7];
                    out_byte <= {out_byte[6:0], 1'b0};
                end
            end
        end
    end

    // start and stop only on the first clock of a byte
    assert property (@(posedge CLK) disable iff (RESET) hi_change |-> (edge_cnt == 4'd1))
        else begin
            proto_errs++;
            $display("%0t: SDA changed while SCL was high in the middle of a byte", $time);
        end

    assert property (@(posedge CLK) disable iff (RESET) done |-> !in_txn)
        else begin
            proto_errs++;
            $display("%0t: transaction ended without a stop condition", $time);
        end

endmodule

// ==== test/tb_eeprom_master.sv ====
`timescale 1ns/100ps

module tb_eeprom_master import eeprom_pkg::*; ();

    localparam int QUARTER = 2;
    localparam int SLOT    = 4 * QUARTER;
    localparam int MAX_OPS = 40;
    localparam int LIMIT   = MAX_OPS * 39 * SLOT + 2520;   // longest op is a read

    logic     CLK;
    logic     RESET;
    logic     wr;
    logic     rd;
    ee_addr_t addr;
    ee_byte_t wdata;
    ee_byte_t rdata;
    logic     busy;
    logic     done;
    logic     nack;
    logic     scl;
    logic     sda_low;
    logic     sda;
    logic     mem_pull;
    logic     present;

    ee_byte_t shadow [2048];
    bit       written [2048];
    ee_addr_t used [$];
    int       mismatches = 0;
    int       level_errs = 0;
    int       accepted = 0;
    int       done_cnt = 0;
    int       cycles = 0;

    assign sda = ~sda_low & ~mem_pull;   // wired-AND of both open drains

    eeprom_master #(.QUARTER(QUARTER)) dut0 (
        .CLK (CLK), .RESET (RESET), .wr (wr), .rd (rd), .addr (addr), .wdata (wdata),
        .rdata (rdata), .busy (busy), .done (done), .nack (nack), .scl (scl),
        .sda_low (sda_low), .sda_in (sda)
    );

    eeprom_model mem0 (
        .CLK (CLK), .RESET (RESET), .scl (scl), .sda (sda), .present (present),
        .done (done), .pull (mem_pull)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles == LIMIT) begin
            $display("Timeout: run did not finish within %0d clock cycles", LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    always @(negedge CLK)
        if (!RESET && done)
            done_cnt++;

    assert property (@(negedge CLK) disable iff (RESET) !busy |-> (scl && !sda_low))
        else begin
            level_errs++;
            $display("Mismatch at %0t: scl,sda_low expected 1,0 got %b,%b", $time, scl, sda_low);
        end

    assert property (@(negedge CLK) disable iff (RESET) done |-> (!busy && $past(busy)))
        else begin
            level_errs++;
            $display("%0t: done pulse did not come with busy falling", $time);
        end

    assert property (@(negedge CLK) disable iff (RESET) $fell(busy) |-> done)
        else begin
            level_errs++;
            $display("%0t: busy fell without a done pulse", $time);
        end

    task automatic expect_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // one strobe, optional stray strobes while busy, then wait for done
    task automatic transfer(input logic is_read, input ee_addr_t a, input ee_byte_t d,
                            input logic stray, output ee_byte_t got, output logic got_nack);
        @(negedge CLK);
        wr    = ~is_read;
        rd    = is_read;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        accepted++;
        expect_value("busy", 1, int'(busy));
        if (stray) begin
            repeat (5) @(negedge CLK);
            wr    = 1'b1;
            rd    = 1'b1;
            addr  = ee_addr_t'($urandom);
            wdata = ee_byte_t'($urandom);
            @(negedge CLK);
            wr = 1'b0;
            rd = 1'b0;
        end
        while (!done)
            @(negedge CLK);
        got      = rdata;
        got_nack = nack;
    endtask

    task automatic write_check(input ee_addr_t a, input ee_byte_t d, input logic stray);
        ee_byte_t got;
        logic     got_nack;
        transfer(1'b0, a, d, stray, got, got_nack);
        expect_value("nack", int'(!present), int'(got_nack));
        if (present) begin
            shadow[a]  = d;
            written[a] = 1'b1;
        end
    endtask

    task automatic read_check(input ee_addr_t a, input logic stray);
        ee_byte_t got;
        logic     got_nack;
        ee_byte_t exp;
        exp = written[a] ? shadow[a] : 8'hFF;   // never written reads erased
        transfer(1'b1, a, 8'h00, stray, got, got_nack);
        expect_value("nack", int'(!present), int'(got_nack));
        if (present)
            expect_value("rdata", int'(exp), int'(got));
    endtask

    function automatic ee_addr_t pick_unwritten();
        ee_addr_t a;
        a = ee_addr_t'($urandom);
        while (written[a])
            a = ee_addr_t'($urandom);
        return a;
    endfunction

    initial begin
        ee_addr_t a;
        int       total;
        void'($urandom(32'h9387_97d4));
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wdata   = '0;
        present = 1'b1;
        RESET   = 1'b1;
        repeat (10) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        expect_value("busy", 0, int'(busy));
        expect_value("done", 0, int'(done));
        expect_value("nack", 0, int'(nack));
        expect_value("scl", 1, int'(scl));
        expect_value("sda_low", 0, int'(sda_low));

        for (int i = 0; i < 12; i++) begin
            a = {3'(i), 8'($urandom)};   // walks through all eight blocks
            write_check(a, 8'($urandom), i == 3);
            used.push_back(a);
        end
        for (int i = 0; i < 12; i++)
            read_check(used[i], i == 5);
        repeat (4)
            read_check(pick_unwritten(), 1'b0);

        // device gone, nothing may change
        present = 1'b0;
        a = used[0];
        write_check(a, ~shadow[a], 1'b1);
        read_check(a, 1'b0);
        present = 1'b1;
        read_check(a, 1'b0);

        repeat (4) @(negedge CLK);
        expect_value("done pulses", accepted, done_cnt);
        total = mismatches + level_errs + mem0.proto_errs;
        $display("Errors: %0d mismatch, %0d level, %0d bus protocol",
                 mismatches, level_errs, mem0.proto_errs);
        if (total == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/eeprom_pkg.sv
source/bus_slot_if.sv
source/scl_timer.sv
source/bus_shifter.sv
source/eeprom_ctrl.sv
source/eeprom_master.sv
test/eeprom_model.sv
test/tb_eeprom_master.sv
